/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_levenshtein
FILELIST  ?= levenshtein_accel.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

/* bench/lev_checker.sv */
// SPI monitor that decodes host read bytes, compares them with queued values and counts errors
module lev_checker (
    input logic spi_ss_n_i,
    input logic spi_sck_i,
    input logic spi_mosi_i,
    input logic spi_miso_i
);
    timeunit 1ns;
    timeprecision 100ps;

    string      exp_name [$];
    logic [7:0] exp_val [$];
    int         chk_cnt = 0;
    int         err_cnt = 0;
    int         bit_pos = 0;
    logic [7:0] mosi_sr = 8'h00;
    logic [7:0] miso_sr = 8'h00;
    logic       rd_xfer = 1'b0;  // Current frame is a read

    task automatic expect_byte(input string name, input logic [7:0] val);
        exp_name.push_back(name);
        exp_val.push_back(val);
    endtask

    task automatic count_error();
        err_cnt++;
    endtask

    task automatic compare_byte(input logic [7:0] act);
        string      name;
        logic [7:0] val;
        if (exp_val.size() == 0) begin
            return;  // Busy polls are not checked here
        end
        name = exp_name.pop_front();
        val  = exp_val.pop_front();
        chk_cnt++;
        if (act !== val) begin
            err_cnt++;
            $display("ERR %s expected 0x%02h actual 0x%02h", name, val, act);
        end
    endtask

    task automatic summarize();
        if (exp_val.size() != 0) begin
            $display("%0d expected read bytes never arrived", exp_val.size());
            err_cnt++;
        end
        $display("Checks: %0d, errors: %0d", chk_cnt, err_cnt);
    endtask

    // Bits are sampled on rising SCK, frame restarts when SS goes high
    always @(posedge spi_sck_i or posedge spi_ss_n_i) begin
        if (spi_ss_n_i) begin
            bit_pos = 0;
        end else begin
            mosi_sr = {mosi_sr[6:0], spi_mosi_i};
            miso_sr = {miso_sr[6:0], spi_miso_i};
            bit_pos++;
            if (bit_pos == 8) begin
                rd_xfer = ~mosi_sr[7];
            end
            if (bit_pos % 8 == 0) begin
                if (bit_pos <= 24) begin
                    if (miso_sr != 8'h00) begin
                        $display("MISO was not low during the command and address bytes");
                        err_cnt++;
                    end
                end else if (rd_xfer) begin
                    compare_byte(miso_sr);
                end
            end
        end
    end

endmodule

/* bench/tb_levenshtein.sv */
// Testbench top with clock, reset, SPI driver tasks, stimulus table and main loop
`include "lev_defines.svh"

module tb_levenshtein;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          N_CASES    = 6;
    localparam int          N_WORDS    = 4;
    localparam int          N_FILL     = 40;
    localparam int          FILL_LEN   = 6;
    localparam int          POLL_LIMIT = 200;
    localparam logic [15:0] MEM_BASE   = 16'h8000;
    localparam logic [15:0] DICT_ADR   = 16'h0040;

    logic clk_i;
    logic arst_n_i;
    logic spi_ss_n_i;
    logic spi_sck_i;
    logic spi_mosi_i;
    logic spi_miso_o;

    logic [31:0] lcg_state;
    logic [7:0]  image [$];  // Bytes of the memory block being built

    // Expected distance and first best index worked out by hand
    string case_name [N_CASES] = '{"exact", "subst", "insert", "delete", "length", "long"};
    string case_pat  [N_CASES] = '{"kitten", "flaw", "abc", "chair", "pattern",
                                   "abcdefghijklmnop"};
    string case_word [N_CASES][N_WORDS] = '{
        '{"sitting", "kitten", "mitten", "bitten"},
        '{"lawn", "flow", "claw", "fla"},
        '{"xyzw", "abxc", "aabc", "abcd"},
        '{"stairs", "chr", "hair", "chai"},
        '{"pat", "patterns", "battery", "tern"},
        '{"abcdefghijklmnoq", "bcdefghijklmnop", "abcdefghijklmnop", "x"}
    };
    int exp_dist [N_CASES] = '{0, 1, 1, 1, 1, 0};
    int exp_idx  [N_CASES] = '{1, 1, 1, 2, 1, 2};

    levenshtein_top i_levenshtein_top (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .spi_ss_n_i(spi_ss_n_i), .spi_sck_i(spi_sck_i),
        .spi_mosi_i(spi_mosi_i), .spi_miso_o(spi_miso_o)
    );

    lev_checker i_checker (
        .spi_ss_n_i(spi_ss_n_i), .spi_sck_i(spi_sck_i),
        .spi_mosi_i(spi_mosi_i), .spi_miso_i(spi_miso_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk_i);
        #2;
    endtask

    // One SS frame, SCK at 1/16 of the clock, MISO taken just before each rise
    task automatic spi_xfer(input logic [7:0] tx [$], output logic [7:0] rx [$]);
        logic [7:0] rx_byte;
        rx = {};
        spi_ss_n_i = 1'b0;
        wait_clks(8);
        foreach (tx[i]) begin
            for (int b = 7; b >= 0; b--) begin
                spi_mosi_i = tx[i][b];
                wait_clks(8);
                rx_byte[b] = spi_miso_o;
                spi_sck_i = 1'b1;
                wait_clks(8);
                spi_sck_i = 1'b0;
            end
            rx.push_back(rx_byte);
        end
        wait_clks(8);
        spi_ss_n_i = 1'b1;
        spi_mosi_i = 1'b0;
        wait_clks(8);
    endtask

    task automatic spi_write(input logic [15:0] addr, input logic [7:0] data [$]);
        logic [7:0] tx [$];
        logic [7:0] rx [$];
        tx = data;
        tx.push_front(addr[7:0]);
        tx.push_front(addr[15:8]);
        tx.push_front(8'h80);
        spi_xfer(tx, rx);
    endtask

    task automatic spi_read(input logic [15:0] addr, input int count, input string name,
                            input logic [7:0] expected [$]);
        logic [7:0] tx [$];
        logic [7:0] rx [$];
        foreach (expected[i]) begin
            i_checker.expect_byte(name, expected[i]);
        end
        tx = {8'h00, addr[15:8], addr[7:0]};
        repeat (count) tx.push_back(8'h00);
        spi_xfer(tx, rx);
    endtask

    task automatic wait_idle(input string name);
        logic [7:0] tx [$];
        logic [7:0] rx [$];
        int         polls;
        logic       busy;
        tx    = {8'h00, 8'h00, {5'd0, `LEV_REG_CTRL}, 8'h00};
        polls = 0;
        busy  = 1'b1;
        while (busy && polls < POLL_LIMIT) begin
            spi_xfer(tx, rx);
            busy = rx[3][0];
            polls++;
        end
        if (busy) begin
            $display("Search for case %s still busy after %0d polls", name, POLL_LIMIT);
            i_checker.count_error();
        end
    endtask

    task automatic append_word(input string s);
        for (int i = 0; i < s.len(); i++) begin
            image.push_back(s[i]);
        end
        image.push_back(8'h00);
    endtask

    // Upper case letters only, so no filler shares a letter with a pattern
    task automatic append_filler();
        for (int i = 0; i < FILL_LEN; i++) begin
            lcg_state = lcg_next(lcg_state);
            image.push_back(8'h51 + 8'(lcg_state[23:16] % 8'd10));
        end
        image.push_back(8'h00);
    endtask

    task automatic run_case(input int c);
        logic [7:0] bytes [$];
        image = {};
        append_word(case_pat[c]);
        spi_write(MEM_BASE, image);
        image = {};
        for (int w = 0; w < N_WORDS; w++) begin
            append_word(case_word[c][w]);
        end
        repeat (N_FILL) append_filler();
        image.push_back(8'h00);  // Empty word ends the dictionary
        spi_write(MEM_BASE | DICT_ADR, image);
        bytes = {DICT_ADR[7:0], DICT_ADR[15:8]};
        spi_write(16'h0000 | `LEV_REG_DICT_LO, bytes);
        bytes = {8'h01};
        spi_write(16'h0000 | `LEV_REG_CTRL, bytes);
        spi_read(16'h0000 | `LEV_REG_CTRL, 1, {case_name[c], "_busy"}, bytes);
        bytes = image[0:3];
        spi_read(MEM_BASE | DICT_ADR, 4, {case_name[c], "_mem"}, bytes);
        wait_idle(case_name[c]);
        bytes = {8'(case_pat[c].len()), DICT_ADR[7:0], DICT_ADR[15:8],
                 8'(exp_dist[c]), 8'(exp_idx[c]), 8'h00};
        spi_read(16'h0000 | `LEV_REG_LEN, 6, case_name[c], bytes);
    endtask

    initial begin
        logic [7:0] bytes [$];
        arst_n_i   = 1'b0;
        spi_ss_n_i = 1'b1;
        spi_sck_i  = 1'b0;
        spi_mosi_i = 1'b0;
        lcg_state  = 32'hfeec;
        repeat (5) @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        wait_clks(4);

        bytes = {8'h00, 8'h00, 8'h00, 8'h00, 8'hFF};  // CTRL through BEST_DIST
        spi_read(16'h0000, 5, "reset", bytes);

        bytes = {8'h5A, 8'hA5, 8'h3C, 8'h00, 8'hFF, 8'h81};
        spi_write(16'h8300, bytes);
        spi_read(16'h8300, 6, "mem_rw_a", bytes);
        bytes = {8'h12, 8'h34, 8'hC7};
        spi_write(16'h83F0, bytes);
        spi_read(16'h83F0, 3, "mem_rw_b", bytes);

        for (int c = 0; c < N_CASES; c++) begin
            run_case(c);
        end

        i_checker.summarize();
        if (i_checker.err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* hdl/lev_defines.svh */
// Bus and memory address widths, bitvector width and controller register offsets
`ifndef LEV_DEFINES_SVH
`define LEV_DEFINES_SVH

`define LEV_BUS_AW 16  // Host and master byte address
`define LEV_MEM_AW 10  // 1 KiB dictionary memory
`define LEV_BV_W   16  // Myers bitvector, also max pattern length

// Controller register offsets, offset 7 reads zero
`define LEV_REG_CTRL      3'd0
`define LEV_REG_LEN       3'd1
`define LEV_REG_DICT_LO   3'd2
`define LEV_REG_DICT_HI   3'd3
`define LEV_REG_BEST_DIST 3'd4
`define LEV_REG_IDX_LO    3'd5
`define LEV_REG_IDX_HI    3'd6

`endif

/* hdl/lev_pkg.sv */
// Bus address, data, memory address, bitvector, distance and word index types
`include "lev_defines.svh"

package lev_pkg;

    typedef logic [`LEV_BUS_AW-1:0] bus_addr_t;  // Bit 15 set selects memory
    typedef logic [7:0]             byte_t;
    typedef logic [`LEV_MEM_AW-1:0] mem_addr_t;
    typedef logic [`LEV_BV_W-1:0]   bitvec_t;    // Vertical or horizontal deltas
    typedef logic [7:0]             dist_t;
    typedef logic [15:0]            word_idx_t;

endpackage

/* hdl/levenshtein_controller.sv */
// Register slave and dictionary scan engine with the Myers bit-parallel distance update
`include "lev_defines.svh"

module levenshtein_controller (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               wbs_cyc_i,
    input  logic               wbs_stb_i,
    input  logic               wbs_we_i,
    input  logic [2:0]         wbs_adr_i,
    input  lev_pkg::byte_t     wbs_dat_i,
    output logic               wbs_ack_o,
    output lev_pkg::byte_t     wbs_dat_o,
    output logic               wbm_cyc_o,
    output logic               wbm_stb_o,
    output logic               wbm_we_o,
    output lev_pkg::mem_addr_t wbm_adr_o,
    output lev_pkg::byte_t     wbm_dat_o,
    input  logic               wbm_ack_i,
    input  lev_pkg::byte_t     wbm_dat_i
);

    localparam int IW = $clog2(`LEV_BV_W);

    typedef enum logic [1:0] {ST_IDLE, ST_PAT, ST_TXT} state_t;

    state_t             state;
    lev_pkg::byte_t     pat [`LEV_BV_W];
    lev_pkg::dist_t     len;  // Also the load index while fetching the pattern
    lev_pkg::dist_t     score;
    lev_pkg::dist_t     best_dist;
    lev_pkg::bus_addr_t dict;
    lev_pkg::word_idx_t word_idx;
    lev_pkg::word_idx_t best_idx;
    lev_pkg::mem_addr_t rd_adr;
    lev_pkg::bitvec_t   pv, mv, eq, xv, xh, ph, mh, ph_sh, mh_sh;
    lev_pkg::byte_t     reg_rdata;
    logic [IW-1:0]      top_idx;
    logic               req, rd_done, word_start, busy, wbs_wr, start;

    assign busy      = (state != ST_IDLE);
    assign wbs_wr    = wbs_cyc_i & wbs_stb_i & wbs_we_i & ~wbs_ack_o;
    assign start     = wbs_wr & (wbs_adr_i == `LEV_REG_CTRL) & wbs_dat_i[0] & ~busy;
    assign rd_done   = req & wbm_ack_i;
    assign wbm_cyc_o = req;
    assign wbm_stb_o = req;
    assign wbm_we_o  = 1'b0;  // Engine only reads
    assign wbm_dat_o = '0;
    assign wbm_adr_o = rd_adr;
    assign top_idx   = IW'(len - 8'd1);

    // Match vector of the incoming text character
    always_comb begin
        for (int i = 0; i < `LEV_BV_W; i++) begin
            eq[i] = (i < int'(len)) && (pat[i] == wbm_dat_i);
        end
    end

    assign xv    = eq | mv;
    assign xh    = (((eq & pv) + pv) ^ pv) | eq;
    assign ph    = mv | ~(xh | pv);
    assign mh    = pv & xh;
    assign ph_sh = {ph[`LEV_BV_W-2:0], 1'b1};  // Global distance, top row grows by one
    assign mh_sh = {mh[`LEV_BV_W-2:0], 1'b0};

    always_ff @(posedge clk_i) begin
        if (rd_done && state == ST_PAT && wbm_dat_i != 8'h00) begin
            pat[len[IW-1:0]] <= wbm_dat_i;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state      <= ST_IDLE;
            req        <= 1'b0;
            len        <= '0;
            score      <= '0;
            best_dist  <= 8'hFF;
            best_idx   <= '0;
            dict       <= '0;
            word_idx   <= '0;
            rd_adr     <= '0;
            pv         <= '1;
            mv         <= '0;
            word_start <= 1'b1;
        end else begin
            if (wbs_wr && wbs_adr_i == `LEV_REG_DICT_LO) dict[7:0] <= wbs_dat_i;
            if (wbs_wr && wbs_adr_i == `LEV_REG_DICT_HI) dict[15:8] <= wbs_dat_i;

            if (start) begin
                state     <= ST_PAT;
                len       <= '0;
                rd_adr    <= '0;
                best_dist <= 8'hFF;
                best_idx  <= '0;
            end else if (rd_done) begin
                req    <= 1'b0;
                rd_adr <= rd_adr + 1'b1;
                if (state == ST_PAT) begin
                    if (wbm_dat_i == 8'h00) begin  // Pattern complete, start the scan
                        state      <= (len == '0) ? ST_IDLE : ST_TXT;
                        rd_adr     <= dict[`LEV_MEM_AW-1:0];
                        pv         <= '1;
                        mv         <= '0;
                        score      <= len;
                        word_idx   <= '0;
                        word_start <= 1'b1;
                    end else begin
                        len <= len + 1'b1;
                    end
                end else if (wbm_dat_i == 8'h00) begin
                    if (word_start) begin  // Empty word ends the dictionary
                        state <= ST_IDLE;
                    end else begin
                        if (score < best_dist) begin
                            best_dist <= score;
                            best_idx  <= word_idx;
                        end
                        word_idx   <= word_idx + 1'b1;
                        pv         <= '1;
                        mv         <= '0;
                        score      <= len;
                        word_start <= 1'b1;
                    end
                end else begin
                    pv         <= mh_sh | ~(xv | ph_sh);
                    mv         <= ph_sh & xv;
                    word_start <= 1'b0;
                    if (ph[top_idx]) begin
                        score <= score + 1'b1;
                    end else if (mh[top_idx]) begin
                        score <= score - 1'b1;
                    end
                end
            end else if (!req && busy) begin
                req <= 1'b1;
            end
        end
    end

    always_comb begin
        case (wbs_adr_i)
            `LEV_REG_CTRL:      reg_rdata = {7'b0, busy};
            `LEV_REG_LEN:       reg_rdata = len;
            `LEV_REG_DICT_LO:   reg_rdata = dict[7:0];
            `LEV_REG_DICT_HI:   reg_rdata = dict[15:8];
            `LEV_REG_BEST_DIST: reg_rdata = best_dist;
            `LEV_REG_IDX_LO:    reg_rdata = best_idx[7:0];
            `LEV_REG_IDX_HI:    reg_rdata = best_idx[15:8];
            default:            reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wbs_ack_o <= 1'b0;
            wbs_dat_o <= '0;
        end else begin
            wbs_ack_o <= wbs_cyc_i & wbs_stb_i & ~wbs_ack_o;
            wbs_dat_o <= reg_rdata;
        end
    end

    // Memory acks only arrive while an engine read is outstanding
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wbm_ack_i |-> wbm_stb_o);

    // Score increments never wrap past 255
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        rd_done && state == ST_TXT && wbm_dat_i != 8'h00 && ph[top_idx] |-> score != 8'hFF);

endmodule

/* hdl/levenshtein_top.sv */
// Top level joining the SPI bridge, decoder, arbiter, controller and dictionary memory
module levenshtein_top (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic spi_ss_n_i,
    input  logic spi_sck_i,
    input  logic spi_mosi_i,
    output logic spi_miso_o
);

    // Host bus from the bridge
    logic               h_cyc, h_stb, h_we, h_ack;
    lev_pkg::bus_addr_t h_adr;
    lev_pkg::byte_t     h_dat_w, h_dat_r;
    // Register slave
    logic               r_cyc, r_stb, r_we, r_ack;
    logic [2:0]         r_adr;
    lev_pkg::byte_t     r_dat_w, r_dat_r;
    // Host memory path into arbiter port 0
    logic               hm_cyc, hm_stb, hm_we, hm_ack;
    lev_pkg::mem_addr_t hm_adr;
    lev_pkg::byte_t     hm_dat_w, hm_dat_r;
    // Controller master into arbiter port 1
    logic               cm_cyc, cm_stb, cm_we, cm_ack;
    lev_pkg::mem_addr_t cm_adr;
    lev_pkg::byte_t     cm_dat_w, cm_dat_r;
    // Arbiter to memory
    logic               m_cyc, m_stb, m_we, m_ack;
    lev_pkg::mem_addr_t m_adr;
    lev_pkg::byte_t     m_dat_w, m_dat_r;

    spi_wishbone_bridge i_bridge (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .spi_ss_n_i(spi_ss_n_i), .spi_sck_i(spi_sck_i),
        .spi_mosi_i(spi_mosi_i), .spi_miso_o(spi_miso_o),
        .cyc_o(h_cyc), .stb_o(h_stb), .we_o(h_we), .adr_o(h_adr),
        .dat_o(h_dat_w), .ack_i(h_ack), .dat_i(h_dat_r)
    );

    wb_interconnect i_interconnect (
        .cyc_i(h_cyc), .stb_i(h_stb), .we_i(h_we), .adr_i(h_adr),
        .dat_i(h_dat_w), .ack_o(h_ack), .dat_o(h_dat_r),
        .reg_cyc_o(r_cyc), .reg_stb_o(r_stb), .reg_we_o(r_we), .reg_adr_o(r_adr),
        .reg_dat_o(r_dat_w), .reg_ack_i(r_ack), .reg_dat_i(r_dat_r),
        .mem_cyc_o(hm_cyc), .mem_stb_o(hm_stb), .mem_we_o(hm_we), .mem_adr_o(hm_adr),
        .mem_dat_o(hm_dat_w), .mem_ack_i(hm_ack), .mem_dat_i(hm_dat_r)
    );

    wb_arbiter i_arbiter (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .s0_cyc_i(hm_cyc), .s0_stb_i(hm_stb), .s0_we_i(hm_we), .s0_adr_i(hm_adr),
        .s0_dat_i(hm_dat_w), .s0_ack_o(hm_ack), .s0_dat_o(hm_dat_r),
        .s1_cyc_i(cm_cyc), .s1_stb_i(cm_stb), .s1_we_i(cm_we), .s1_adr_i(cm_adr),
        .s1_dat_i(cm_dat_w), .s1_ack_o(cm_ack), .s1_dat_o(cm_dat_r),
        .m_cyc_o(m_cyc), .m_stb_o(m_stb), .m_we_o(m_we), .m_adr_o(m_adr),
        .m_dat_o(m_dat_w), .m_ack_i(m_ack), .m_dat_i(m_dat_r)
    );

    levenshtein_controller i_controller (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .wbs_cyc_i(r_cyc), .wbs_stb_i(r_stb), .wbs_we_i(r_we), .wbs_adr_i(r_adr),
        .wbs_dat_i(r_dat_w), .wbs_ack_o(r_ack), .wbs_dat_o(r_dat_r),
        .wbm_cyc_o(cm_cyc), .wbm_stb_o(cm_stb), .wbm_we_o(cm_we), .wbm_adr_o(cm_adr),
        .wbm_dat_o(cm_dat_w), .wbm_ack_i(cm_ack), .wbm_dat_i(cm_dat_r)
    );

    word_memory i_memory (
        .clk_i(clk_i), .arst_n_i(arst_n_i),
        .cyc_i(m_cyc), .stb_i(m_stb), .we_i(m_we), .adr_i(m_adr),
        .dat_i(m_dat_w), .ack_o(m_ack), .dat_o(m_dat_r)
    );

endmodule

/* hdl/spi_wishbone_bridge.sv */
// Mode-0 SPI slave that turns command, address and data bytes into bus cycles
module spi_wishbone_bridge (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               spi_ss_n_i,
    input  logic               spi_sck_i,
    input  logic               spi_mosi_i,
    output logic               spi_miso_o,
    output logic               cyc_o,
    output logic               stb_o,
    output logic               we_o,
    output lev_pkg::bus_addr_t adr_o,
    output lev_pkg::byte_t     dat_o,
    input  logic               ack_i,
    input  lev_pkg::byte_t     dat_i
);

    typedef enum logic [1:0] {PH_CMD, PH_ADR_HI, PH_ADR_LO, PH_DATA} phase_t;

    logic [2:0]     sck_q;   // Two sync stages plus previous value
    logic [1:0]     ss_q;
    logic [1:0]     mosi_q;
    phase_t         phase;
    logic [2:0]     bit_cnt;
    logic           wr_mode;
    lev_pkg::byte_t rx_sr;
    lev_pkg::byte_t tx_sr;
    lev_pkg::byte_t rd_buf;  // Last byte fetched by a bus read
    lev_pkg::byte_t rx_byte;
    logic           sck_rise;
    logic           sck_fall;
    logic           ss_active;
    logic           byte_done;

    assign sck_rise   = sck_q[1] & ~sck_q[2];
    assign sck_fall   = ~sck_q[1] & sck_q[2];
    assign ss_active  = ~ss_q[1];
    assign rx_byte    = {rx_sr[6:0], mosi_q[1]};
    assign byte_done  = ss_active & sck_rise & (bit_cnt == 3'd7);
    assign spi_miso_o = tx_sr[7];
    assign we_o       = wr_mode;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sck_q   <= '0;
            ss_q    <= '1;
            mosi_q  <= '0;
            phase   <= PH_CMD;
            bit_cnt <= '0;
            wr_mode <= 1'b0;
            rx_sr   <= '0;
            tx_sr   <= '0;
            rd_buf  <= '0;
            cyc_o   <= 1'b0;
            stb_o   <= 1'b0;
            adr_o   <= '0;
            dat_o   <= '0;
        end else begin
            sck_q  <= {sck_q[1:0], spi_sck_i};
            ss_q   <= {ss_q[0], spi_ss_n_i};
            mosi_q <= {mosi_q[0], spi_mosi_i};

            if (ack_i) begin  // Cycle done, step to next address
                cyc_o <= 1'b0;
                stb_o <= 1'b0;
                adr_o <= adr_o + 1'b1;
                if (!wr_mode) begin
                    rd_buf <= dat_i;
                end
            end

            if (!ss_active) begin
                phase   <= PH_CMD;
                bit_cnt <= '0;
                tx_sr   <= '0;
            end else begin
                if (sck_rise) begin
                    rx_sr   <= rx_byte;
                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (sck_fall) begin  // Load fetched byte at start of a read data byte
                    if (bit_cnt == 3'd0 && phase == PH_DATA && !wr_mode) begin
                        tx_sr <= rd_buf;
                    end else begin
                        tx_sr <= {tx_sr[6:0], 1'b0};
                    end
                end
                if (byte_done) begin
                    case (phase)
                        PH_CMD: begin
                            wr_mode <= rx_byte[7];
                            phase   <= PH_ADR_HI;
                        end
                        PH_ADR_HI: begin
                            adr_o[15:8] <= rx_byte;
                            phase       <= PH_ADR_LO;
                        end
                        PH_ADR_LO: begin
                            adr_o[7:0] <= rx_byte;
                            phase      <= PH_DATA;
                            cyc_o      <= ~wr_mode;  // Prefetch first read byte
                            stb_o      <= ~wr_mode;
                        end
                        default: begin
                            dat_o <= wr_mode ? rx_byte : dat_o;
                            cyc_o <= 1'b1;
                            stb_o <= 1'b1;
                        end
                    endcase
                end
            end
        end
    end

    // Request held with a stable address until acknowledged
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        stb_o && !ack_i |=> stb_o && cyc_o && $stable(adr_o));

endmodule

/* hdl/wb_arbiter.sv */
// Round-robin two-port arbiter in front of the dictionary memory
module wb_arbiter (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               s0_cyc_i,
    input  logic               s0_stb_i,
    input  logic               s0_we_i,
    input  lev_pkg::mem_addr_t s0_adr_i,
    input  lev_pkg::byte_t     s0_dat_i,
    output logic               s0_ack_o,
    output lev_pkg::byte_t     s0_dat_o,
    input  logic               s1_cyc_i,
    input  logic               s1_stb_i,
    input  logic               s1_we_i,
    input  lev_pkg::mem_addr_t s1_adr_i,
    input  lev_pkg::byte_t     s1_dat_i,
    output logic               s1_ack_o,
    output lev_pkg::byte_t     s1_dat_o,
    output logic               m_cyc_o,
    output logic               m_stb_o,
    output logic               m_we_o,
    output lev_pkg::mem_addr_t m_adr_o,
    output lev_pkg::byte_t     m_dat_o,
    input  logic               m_ack_i,
    input  lev_pkg::byte_t     m_dat_i
);

    logic owned;  // A port holds the memory
    logic gnt;    // Owning port
    logic last;   // Winner of the previous transfer

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            owned <= 1'b0;
            gnt   <= 1'b0;
            last  <= 1'b1;
        end else if (!owned) begin
            if (s0_cyc_i && s1_cyc_i) begin
                owned <= 1'b1;
                gnt   <= ~last;  // Loser of last round goes first
            end else if (s0_cyc_i || s1_cyc_i) begin
                owned <= 1'b1;
                gnt   <= s1_cyc_i;
            end
        end else if (m_ack_i) begin
            owned <= 1'b0;
            last  <= gnt;
        end
    end

    assign m_cyc_o  = owned & (gnt ? s1_cyc_i : s0_cyc_i);
    assign m_stb_o  = owned & (gnt ? s1_stb_i : s0_stb_i);
    assign m_we_o   = gnt ? s1_we_i : s0_we_i;
    assign m_adr_o  = gnt ? s1_adr_i : s0_adr_i;
    assign m_dat_o  = gnt ? s1_dat_i : s0_dat_i;
    assign s0_ack_o = owned & ~gnt & m_ack_i;
    assign s1_ack_o = owned & gnt & m_ack_i;
    assign s0_dat_o = m_dat_i;
    assign s1_dat_o = m_dat_i;

    // Owning port holds its request until the memory acks
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        owned && !m_ack_i |-> m_cyc_o && m_stb_o);

endmodule

/* hdl/wb_interconnect.sv */
// Host bus decoder routing to the register slave or the memory path by address bit 15
`include "lev_defines.svh"

module wb_interconnect (
    input  logic               cyc_i,
    input  logic               stb_i,
    input  logic               we_i,
    input  lev_pkg::bus_addr_t adr_i,
    input  lev_pkg::byte_t     dat_i,
    output logic               ack_o,
    output lev_pkg::byte_t     dat_o,
    output logic               reg_cyc_o,
    output logic               reg_stb_o,
    output logic               reg_we_o,
    output logic [2:0]         reg_adr_o,
    output lev_pkg::byte_t     reg_dat_o,
    input  logic               reg_ack_i,
    input  lev_pkg::byte_t     reg_dat_i,
    output logic               mem_cyc_o,
    output logic               mem_stb_o,
    output logic               mem_we_o,
    output lev_pkg::mem_addr_t mem_adr_o,
    output lev_pkg::byte_t     mem_dat_o,
    input  logic               mem_ack_i,
    input  lev_pkg::byte_t     mem_dat_i
);

    logic sel_mem;

    assign sel_mem   = adr_i[`LEV_BUS_AW-1];
    assign reg_cyc_o = cyc_i & ~sel_mem;
    assign reg_stb_o = stb_i & ~sel_mem;
    assign reg_we_o  = we_i;
    assign reg_adr_o = adr_i[2:0];
    assign reg_dat_o = dat_i;
    assign mem_cyc_o = cyc_i & sel_mem;
    assign mem_stb_o = stb_i & sel_mem;
    assign mem_we_o  = we_i;
    assign mem_adr_o = adr_i[`LEV_MEM_AW-1:0];
    assign mem_dat_o = dat_i;
    assign ack_o     = sel_mem ? mem_ack_i : reg_ack_i;
    assign dat_o     = sel_mem ? mem_dat_i : reg_dat_i;

    // Only the addressed target ever acknowledges
    assert property (@(posedge reg_ack_i) reg_cyc_o);
    assert property (@(posedge mem_ack_i) mem_cyc_o);

endmodule

/* hdl/word_memory.sv */
// Single-port 1 KiB byte memory behind a bus slave port
`include "lev_defines.svh"

module word_memory (
    input  logic               clk_i,
    input  logic               arst_n_i,
    input  logic               cyc_i,
    input  logic               stb_i,
    input  logic               we_i,
    input  lev_pkg::mem_addr_t adr_i,
    input  lev_pkg::byte_t     dat_i,
    output logic               ack_o,
    output lev_pkg::byte_t     dat_o
);

    lev_pkg::byte_t mem [2**`LEV_MEM_AW];
    logic           access;

    assign access = cyc_i & stb_i & ~ack_o;  // One access per request

    always_ff @(posedge clk_i) begin
        if (access) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= access;
        end
    end

endmodule

/* levenshtein_accel.f */
+incdir+hdl
hdl/lev_pkg.sv
hdl/spi_wishbone_bridge.sv
hdl/wb_interconnect.sv
hdl/wb_arbiter.sv
hdl/levenshtein_controller.sv
hdl/word_memory.sv
hdl/levenshtein_top.sv
bench/lev_checker.sv
bench/tb_levenshtein.sv
